//--- all.f
+incdir+source
source/gomoku_pkg.sv
source/gomoku_wb_regs.sv
source/gomoku_board.sv
source/line_scanner.sv
source/gomoku_result.sv
source/gomoku_top.sv
dv/gomoku_checker.sv
dv/gomoku_tb.sv

//--- dv/gomoku_checker.sv
`timescale 1ns/1ns

module gomoku_checker (
    input logic               clk,
    input logic               rst,
    input logic               cyc,
    input logic               stb,
    input logic               ack,
    input gomoku_pkg::state_t state,
    input gomoku_pkg::cell_t  winner
);
    import gomoku_pkg::*;

    // ------------------------------
    // Bus handshake
    // ------------------------------
    ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb))
        else $error("ack raised outside an active bus cycle");

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack held high for two cycles");

    // A won game always names its winner
    win_has_winner: assert property (@(posedge clk) disable iff (rst)
        (state == S_WIN) |-> (winner != CELL_EMPTY))
        else $error("state is S_WIN while the winner is empty");

endmodule

bind gomoku_top gomoku_checker u_checker (
    .clk(clk), .rst(rst),
    .cyc(cyc), .stb(stb), .ack(ack),
    .state(state), .winner(winner)
);

//--- dv/gomoku_tb.sv
`timescale 1ns/1ns
`include "gomoku_settings.svh"

module gomoku_tb;
    import gomoku_pkg::*;

    localparam int GS          = `GRID_SIZE;
    localparam int CLK_PERIOD  = 40;
    localparam int N_OPS       = 3000;    // Upper bound on bus operations in the run
    localparam int WATCHDOG_NS = N_OPS * 20 * CLK_PERIOD + 2000;

    // Alternating stones from player 1 that leave player 1 a row broken by player 2
    localparam int BRK_X [10] = '{5, 7, 6, 0, 9, 2, 10, 4, 8, 6};
    localparam int BRK_Y [10] = '{5, 5, 5, 9, 5, 9, 5, 9, 5, 9};

    logic                  clk;
    logic                  rst;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`WB_ADDR_W-1:0] adr;
    logic [`WB_DATA_W-1:0] dat_w;
    logic [`WB_DATA_W-1:0] dat_r;
    logic                  ack;
    logic [`WB_DATA_W-1:0] rd;

    // Reference model
    cell_t               m_grid [GS][GS];
    logic [`COORD_W-1:0] m_x;
    logic [`COORD_W-1:0] m_y;
    logic                m_turn;
    state_t              m_state;
    cell_t               m_winner;
    logic [`SCORE_W-1:0] m_s1;
    logic [`SCORE_W-1:0] m_s2;
    int                  checks;
    int                  errors;

    gomoku_top u_gomoku_top (
        .clk(clk), .rst(rst),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .dat_r(dat_r), .ack(ack)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out before all tests finished, %0d errors so far", errors);
        $display("TB FAILED");
        $finish;
    end

    // ------------------------------
    // Bus and checks
    // ------------------------------
    task automatic bus_cycle(input logic write, input logic [`WB_ADDR_W-1:0] addr,
                             input logic [`WB_DATA_W-1:0] wdata,
                             output logic [`WB_DATA_W-1:0] rdata);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        do begin
            @(posedge clk);
            #2;
        end while (!ack);
        rdata = dat_r;
        @(posedge clk);    // Slave drops ack on this edge
        #2;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, got);
        end
    endtask

    function automatic logic [31:0] status_word();
        return {16'd0, m_y, m_x, 3'b000, m_winner, m_turn, m_state};
    endfunction

    task automatic check_state();
        bus_cycle(1'b0, `WB_ADDR_W'(`ADDR_STATUS), '0, rd);
        check_val("status", status_word(), rd);
        bus_cycle(1'b0, `WB_ADDR_W'(`ADDR_SCORES), '0, rd);
        check_val("scores", {16'd0, m_s2, m_s1}, rd);
    endtask

    task automatic check_cell(input int x, input int y);
        bus_cycle(1'b0, {1'b1, 4'(y), 4'(x)}, '0, rd);
        check_val("cell", 32'(m_grid[y][x]), rd);
    endtask

    task automatic check_board();
        for (int y = 0; y < GS; y++) begin
            for (int x = 0; x < GS; x++) begin
                check_cell(x, y);
            end
        end
    endtask

    // ------------------------------
    // Model
    // ------------------------------
    task automatic clear_grid();
        for (int y = 0; y < GS; y++) begin
            for (int x = 0; x < GS; x++) begin
                m_grid[y][x] = CELL_EMPTY;
            end
        end
    endtask

    function automatic bit model_wins(input int r, input int c, input cell_t p);
        int dr [4] = '{0, 1, 1, -1};
        int dc [4] = '{1, 0, 1, 1};
        int n;
        int rr;
        int cc;
        for (int d = 0; d < 4; d++) begin
            n = 1;
            for (int s = -1; s <= 1; s += 2) begin
                rr = r + s * dr[d];
                cc = c + s * dc[d];
                while (rr >= 0 && rr < GS && cc >= 0 && cc < GS && m_grid[rr][cc] == p) begin
                    n++;
                    rr += s * dr[d];
                    cc += s * dc[d];
                end
            end
            if (n >= `WIN_LEN) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic do_cmd(input cmd_t op);
        cell_t cur;
        bus_cycle(1'b1, `WB_ADDR_W'(`ADDR_CMD), 32'(op), rd);
        cur = m_turn ? CELL_P2 : CELL_P1;
        if (m_state == S_WIN) begin
            if (op == CMD_REMATCH) begin    // Scores and cursor stay
                clear_grid();
                m_winner = CELL_EMPTY;
                m_turn   = 1'b0;
                m_state  = S_PLAY;
            end
        end else begin
            case (op)
                CMD_LEFT:  m_x = (m_x == 4'd0) ? 4'(GS - 1) : m_x - 4'd1;
                CMD_RIGHT: m_x = (m_x == 4'(GS - 1)) ? 4'd0 : m_x + 4'd1;
                CMD_UP:    m_y = (m_y == 4'd0) ? 4'(GS - 1) : m_y - 4'd1;
                CMD_DOWN:  m_y = (m_y == 4'(GS - 1)) ? 4'd0 : m_y + 4'd1;
                CMD_PLACE: begin
                    if (m_grid[m_y][m_x] == CELL_EMPTY) begin
                        m_grid[m_y][m_x] = cur;
                        m_turn = ~m_turn;
                        if (model_wins(int'(m_y), int'(m_x), cur)) begin
                            m_state  = S_WIN;
                            m_winner = cur;
                            if (cur == CELL_P1) m_s1 = m_s1 + 8'd1;
                            else m_s2 = m_s2 + 8'd1;
                        end
                    end
                end
                default: ;    // Rematch outside S_WIN
            endcase
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        clear_grid();
        m_x      = 4'(GS / 2);
        m_y      = 4'(GS / 2);
        m_turn   = 1'b0;
        m_state  = S_PLAY;
        m_winner = CELL_EMPTY;
        m_s1     = '0;
        m_s2     = '0;
    endtask

    // ------------------------------
    // Game helpers
    // ------------------------------
    task automatic goto(input int x, input int y);
        while (int'(m_x) != x) begin
            do_cmd(((x - int'(m_x) + GS) % GS <= GS / 2) ? CMD_RIGHT : CMD_LEFT);
        end
        while (int'(m_y) != y) begin
            do_cmd(((y - int'(m_y) + GS) % GS <= GS / 2) ? CMD_DOWN : CMD_UP);
        end
    endtask

    task automatic place_at(input int x, input int y);
        goto(x, y);
        do_cmd(CMD_PLACE);
        check_state();
        check_cell(x, y);
    endtask

    // Five stones for the winner against spaced fillers for the loser
    task automatic win_game(input int x0, input int y0, input int dx, input int dy,
                            input bit p2_wins);
        for (int k = 0; k < `WIN_LEN; k++) begin
            if (p2_wins) place_at(2 * k, 3);
            place_at(x0 + k * dx, y0 + k * dy);
            if (!p2_wins && k < `WIN_LEN - 1) place_at(2 * k, 12);
        end
        // A directed game always ends in a win for the chosen player
        bus_cycle(1'b0, `WB_ADDR_W'(`ADDR_STATUS), '0, rd);
        check_val("state", 32'(S_WIN), 32'(rd[1:0]));
        check_val("winner", p2_wins ? 32'(CELL_P2) : 32'(CELL_P1), 32'(rd[4:3]));
    endtask

    task automatic win_state_checks();
        do_cmd(CMD_RIGHT);
        do_cmd(CMD_PLACE);
        check_state();
        check_cell(int'(m_x), int'(m_y));
        do_cmd(CMD_REMATCH);
        check_state();
    endtask

    initial begin
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        rst    = 1'b1;
        checks = 0;
        errors = 0;
        void'($urandom(34));
        apply_reset();

        // Reset values and an ignored rematch while playing
        check_state();
        check_cell(0, 0);
        check_cell(7, 7);
        check_cell(14, 14);
        check_cell(3, 11);
        do_cmd(CMD_REMATCH);
        check_state();

        // Illegal opcodes and writes elsewhere
        bus_cycle(1'b1, `WB_ADDR_W'(`ADDR_CMD), 32'd6, rd);
        bus_cycle(1'b1, `WB_ADDR_W'(`ADDR_CMD), 32'd7, rd);
        bus_cycle(1'b1, `WB_ADDR_W'(`ADDR_CMD), 32'h104, rd);    // Low bits look like a place
        bus_cycle(1'b1, `WB_ADDR_W'(`ADDR_STATUS), 32'(CMD_PLACE), rd);
        bus_cycle(1'b1, `WB_ADDR_W'(`ADDR_SCORES), 32'(CMD_PLACE), rd);
        bus_cycle(1'b1, 9'h003, 32'(CMD_PLACE), rd);
        bus_cycle(1'b1, 9'h177, 32'(CMD_PLACE), rd);
        check_state();
        check_cell(7, 7);
        bus_cycle(1'b0, {1'b1, 4'd15, 4'd3}, '0, rd);
        check_val("dat_r", 32'd0, rd);
        bus_cycle(1'b0, {1'b1, 4'd2, 4'd15}, '0, rd);
        check_val("dat_r", 32'd0, rd);

        // Random cursor walk
        for (int i = 0; i < 200; i++) begin
            do_cmd(cmd_t'($urandom_range(3, 0)));
            check_state();
        end

        // Random moves and places
        for (int i = 0; i < 150; i++) begin
            if ($urandom_range(1, 0) == 0) begin
                do_cmd(CMD_PLACE);
                check_cell(int'(m_x), int'(m_y));
            end else begin
                do_cmd(cmd_t'($urandom_range(3, 0)));
            end
            check_state();
        end
        do_cmd(CMD_REMATCH);    // Only acts if a random game was won
        check_board();

        // Directed games on a fresh board
        apply_reset();
        for (int i = 0; i < 10; i++) place_at(BRK_X[i], BRK_Y[i]);
        win_game(0, 0, 1, 0, 1'b0);      // Player 1 along row 0 from the left edge
        win_state_checks();
        check_board();
        win_game(14, 10, 0, 1, 1'b0);    // Player 1 down the right edge
        win_state_checks();
        win_game(10, 10, 1, 1, 1'b1);    // Player 2 into the bottom-right corner
        win_state_checks();
        win_game(0, 14, 1, -1, 1'b1);    // Player 2 up-right from the bottom-left corner
        win_state_checks();

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the Gomoku testbench under Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module gomoku_tb -f all.f -o gomoku_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

# A simulator that stops on an assertion still counts as a failed run
./obj_dir/gomoku_sim > sim.log 2>&1 || echo "TB FAILED" >> sim.log
cat sim.log

grep -q "TB FAILED" sim.log && { echo "Result: FAIL"; exit 1; } || echo "Result: PASS"

//--- source/gomoku_board.sv
`timescale 1ns/1ns
`include "gomoku_settings.svh"

module gomoku_board (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cmd_valid,
    input  gomoku_pkg::cmd_t                       cmd_op,
    output logic                                   cmd_done,
    input  logic [`COORD_W-1:0]                    cell_row,
    input  logic [`COORD_W-1:0]                    cell_col,
    output gomoku_pkg::cell_t                      cell_rd,
    input  logic                                   game_over,
    output gomoku_pkg::state_t                     state,
    output logic                                   turn,
    output logic [`COORD_W-1:0]                    cursor_x,
    output logic [`COORD_W-1:0]                    cursor_y,
    output logic                                   scan_valid,
    output gomoku_pkg::cell_t                      scan_player,
    output gomoku_pkg::cell_t [`WINDOW_LEN-1:0]    window_0,
    output gomoku_pkg::cell_t [`WINDOW_LEN-1:0]    window_1,
    output gomoku_pkg::cell_t [`WINDOW_LEN-1:0]    window_2,
    output gomoku_pkg::cell_t [`WINDOW_LEN-1:0]    window_3,
    output logic                                   new_round
);
    import gomoku_pkg::*;

    localparam int GS  = `GRID_SIZE;
    localparam int CW  = `COORD_W;
    localparam int CTR = `WIN_LEN - 1;    // Window index of the placed cell

    localparam logic [CW-1:0] EDGE      = CW'(GS - 1);
    localparam logic [CW-1:0] MID       = CW'(GS / 2);
    localparam logic [1:0]    SCAN_LAST = 2'd2;    // game_over settled on this scan cycle

    cell_t         grid [GS][GS];
    logic [CW-1:0] last_row;
    logic [CW-1:0] last_col;
    logic [1:0]    scan_cnt;
    logic          accept;
    logic          do_place;
    cell_t         turn_cell;

    function automatic cell_t cell_at(input int r, input int c);
        if (r < 0 || r >= GS || c < 0 || c >= GS) begin
            return CELL_EMPTY;
        end
        return grid[r][c];
    endfunction

    // cmd_valid is still up during the done pulse
    assign accept    = cmd_valid && !cmd_done;
    assign turn_cell = turn ? CELL_P2 : CELL_P1;
    assign do_place  = accept && state == S_PLAY && cmd_op == CMD_PLACE &&
                       grid[cursor_y][cursor_x] == CELL_EMPTY;

    always_comb begin
        cell_rd = cell_at(int'(cell_row), int'(cell_col));
    end

    // ------------------------------
    // Game FSM and grid
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_PLAY;
            turn       <= 1'b0;
            cursor_x   <= MID;
            cursor_y   <= MID;
            cmd_done   <= 1'b0;
            scan_valid <= 1'b0;
            scan_cnt   <= 2'd0;
            new_round  <= 1'b0;
            for (int r = 0; r < GS; r++) begin
                for (int c = 0; c < GS; c++) begin
                    grid[r][c] <= CELL_EMPTY;
                end
            end
        end else begin
            cmd_done   <= 1'b0;
            scan_valid <= 1'b0;
            new_round  <= 1'b0;
            case (state)
                S_PLAY: begin
                    if (do_place) begin
                        grid[cursor_y][cursor_x] <= turn_cell;
                        turn       <= ~turn;
                        scan_valid <= 1'b1;
                        scan_cnt   <= 2'd0;
                        state      <= S_SCAN;
                    end else if (accept) begin
                        cmd_done <= 1'b1;    // Occupied place and rematch fall through here
                        case (cmd_op)
                            CMD_LEFT:  cursor_x <= (cursor_x == '0) ? EDGE : cursor_x - CW'(1);
                            CMD_RIGHT: cursor_x <= (cursor_x == EDGE) ? '0 : cursor_x + CW'(1);
                            CMD_UP:    cursor_y <= (cursor_y == '0) ? EDGE : cursor_y - CW'(1);
                            CMD_DOWN:  cursor_y <= (cursor_y == EDGE) ? '0 : cursor_y + CW'(1);
                            default:   ;
                        endcase
                    end
                end
                S_SCAN: begin
                    scan_cnt <= scan_cnt + 2'd1;
                    if (scan_cnt == SCAN_LAST) begin
                        state    <= game_over ? S_WIN : S_PLAY;
                        cmd_done <= 1'b1;
                    end
                end
                S_WIN: begin
                    if (accept) begin
                        cmd_done <= 1'b1;
                        if (cmd_op == CMD_REMATCH) begin
                            // Cursor and scores survive the rematch
                            for (int r = 0; r < GS; r++) begin
                                for (int c = 0; c < GS; c++) begin
                                    grid[r][c] <= CELL_EMPTY;
                                end
                            end
                            turn      <= 1'b0;
                            new_round <= 1'b1;
                            state     <= S_PLAY;
                        end
                    end
                end
                default: state <= S_PLAY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_place) begin
            last_row    <= cursor_y;
            last_col    <= cursor_x;
            scan_player <= turn_cell;
        end
    end

    // Four lines through the last stone
    always_comb begin
        int off;
        int r0;
        int c0;
        r0 = int'(last_row);
        c0 = int'(last_col);
        for (int k = 0; k < `WINDOW_LEN; k++) begin
            off = k - CTR;
            window_0[k] = cell_at(r0, c0 + off);          // Horizontal
            window_1[k] = cell_at(r0 + off, c0);          // Vertical
            window_2[k] = cell_at(r0 + off, c0 + off);    // Down-right
            window_3[k] = cell_at(r0 - off, c0 + off);    // Up-right
        end
    end

endmodule

//--- source/gomoku_pkg.sv
package gomoku_pkg;

    // Contents of one board cell
    typedef enum logic [1:0] {
        CELL_EMPTY = 2'd0,
        CELL_P1    = 2'd1,
        CELL_P2    = 2'd2
    } cell_t;

    // Game FSM
    typedef enum logic [1:0] {
        S_PLAY = 2'd0,
        S_SCAN = 2'd1,    // Win check in flight
        S_WIN  = 2'd2
    } state_t;

    // Opcodes written to the command register
    typedef enum logic [2:0] {
        CMD_LEFT    = 3'd0,
        CMD_RIGHT   = 3'd1,
        CMD_UP      = 3'd2,
        CMD_DOWN    = 3'd3,
        CMD_PLACE   = 3'd4,
        CMD_REMATCH = 3'd5
    } cmd_t;

endpackage

//--- source/gomoku_result.sv
`timescale 1ns/1ns
`include "gomoku_settings.svh"

module gomoku_result (
    input  logic                clk,
    input  logic                rst,
    input  logic                hit_valid,
    input  logic [3:0]          hits,
    input  gomoku_pkg::cell_t   scan_player,
    input  logic                new_round,
    output logic                game_over,
    output gomoku_pkg::cell_t   winner,
    output logic [`SCORE_W-1:0] score_p1,
    output logic [`SCORE_W-1:0] score_p2
);
    import gomoku_pkg::*;

    localparam int SW = `SCORE_W;

    logic any_hit;

    assign any_hit = hit_valid && (|hits);    // Any direction is enough

    always_ff @(posedge clk) begin
        if (rst) begin
            game_over <= 1'b0;
            winner    <= CELL_EMPTY;
            score_p1  <= '0;
            score_p2  <= '0;
        end else if (new_round) begin
            game_over <= 1'b0;
            winner    <= CELL_EMPTY;
        end else if (any_hit) begin
            game_over <= 1'b1;
            winner    <= scan_player;
            // Counters roll over past the top
            if (scan_player == CELL_P1) begin
                score_p1 <= score_p1 + SW'(1);
            end else begin
                score_p2 <= score_p2 + SW'(1);
            end
        end
    end

endmodule

//--- source/gomoku_settings.svh
`ifndef GOMOKU_SETTINGS_SVH
`define GOMOKU_SETTINGS_SVH

// Board geometry
`define GRID_SIZE       15
`define WIN_LEN         5
`define WINDOW_LEN      9    // 2*WIN_LEN - 1 cells centred on the placed stone

`define COORD_W         4
`define SCORE_W         8

// ------------------------------
// Wishbone register map
// ------------------------------
`define WB_ADDR_W       9
`define WB_DATA_W       32

`define ADDR_CMD        0
`define ADDR_STATUS     1
`define ADDR_SCORES     2
`define CELL_SPACE_BIT  8    // Set for cell reads with the row in 7..4 and the column in 3..0

`endif

//--- source/gomoku_top.sv
`timescale 1ns/1ns
`include "gomoku_settings.svh"

module gomoku_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [`WB_ADDR_W-1:0] adr,
    input  logic [`WB_DATA_W-1:0] dat_w,
    output logic [`WB_DATA_W-1:0] dat_r,
    output logic                  ack
);
    import gomoku_pkg::*;

    // Command handshake
    logic                 cmd_valid;
    cmd_t                 cmd_op;
    logic                 cmd_done;

    state_t               state;
    logic                 turn;
    cell_t                winner;
    logic [`COORD_W-1:0]  cursor_x;
    logic [`COORD_W-1:0]  cursor_y;
    logic [`SCORE_W-1:0]  score_p1;
    logic [`SCORE_W-1:0]  score_p2;

    logic [`COORD_W-1:0]  cell_row;
    logic [`COORD_W-1:0]  cell_col;
    cell_t                cell_rd;

    // ------------------------------
    // Scan path
    // ------------------------------
    logic                    scan_valid;
    cell_t                   scan_player;
    cell_t [`WINDOW_LEN-1:0] windows [4];    // H, V, down-right, up-right
    logic [3:0]              hits;
    logic [3:0]              hit_valids;
    logic                    game_over;
    logic                    new_round;

    gomoku_wb_regs u_regs (
        .clk(clk), .rst(rst),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .ack(ack), .dat_r(dat_r),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_done(cmd_done),
        .state(state), .turn(turn), .winner(winner),
        .cursor_x(cursor_x), .cursor_y(cursor_y),
        .score_p1(score_p1), .score_p2(score_p2),
        .cell_row(cell_row), .cell_col(cell_col), .cell_rd(cell_rd)
    );

    gomoku_board u_board (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_done(cmd_done),
        .cell_row(cell_row), .cell_col(cell_col), .cell_rd(cell_rd),
        .game_over(game_over),
        .state(state), .turn(turn),
        .cursor_x(cursor_x), .cursor_y(cursor_y),
        .scan_valid(scan_valid), .scan_player(scan_player),
        .window_0(windows[0]), .window_1(windows[1]),
        .window_2(windows[2]), .window_3(windows[3]),
        .new_round(new_round)
    );

    for (genvar d = 0; d < 4; d++) begin : g_scan
        line_scanner u_scan (
            .clk(clk), .rst(rst),
            .scan_valid(scan_valid), .scan_player(scan_player),
            .window(windows[d]),
            .hit(hits[d]), .hit_valid(hit_valids[d])
        );
    end

    // Scanners run in lockstep
    gomoku_result u_result (
        .clk(clk), .rst(rst),
        .hit_valid(&hit_valids), .hits(hits),
        .scan_player(scan_player), .new_round(new_round),
        .game_over(game_over), .winner(winner),
        .score_p1(score_p1), .score_p2(score_p2)
    );

endmodule

//--- source/gomoku_wb_regs.sv
`timescale 1ns/1ns
`include "gomoku_settings.svh"

module gomoku_wb_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [`WB_ADDR_W-1:0] adr,
    input  logic [`WB_DATA_W-1:0] dat_w,
    output logic                  ack,
    output logic [`WB_DATA_W-1:0] dat_r,
    output logic                  cmd_valid,
    output gomoku_pkg::cmd_t      cmd_op,
    input  logic                  cmd_done,
    input  gomoku_pkg::state_t    state,
    input  logic                  turn,
    input  gomoku_pkg::cell_t     winner,
    input  logic [`COORD_W-1:0]   cursor_x,
    input  logic [`COORD_W-1:0]   cursor_y,
    input  logic [`SCORE_W-1:0]   score_p1,
    input  logic [`SCORE_W-1:0]   score_p2,
    output logic [`COORD_W-1:0]   cell_row,
    output logic [`COORD_W-1:0]   cell_col,
    input  gomoku_pkg::cell_t     cell_rd
);
    import gomoku_pkg::*;

    localparam int AW = `WB_ADDR_W;
    localparam int DW = `WB_DATA_W;
    localparam int CW = `COORD_W;

    logic          new_req;
    logic          is_cmd_addr;
    logic          op_legal;
    logic [DW-1:0] rd_word;

    // Fresh cycle that is neither an answered tail nor a command in flight
    assign new_req     = cyc && stb && !ack && !cmd_valid;
    assign is_cmd_addr = adr == AW'(`ADDR_CMD);
    assign op_legal    = dat_w <= DW'(CMD_REMATCH);

    // Cell address goes straight to the board
    assign cell_row = adr[2*CW-1:CW];
    assign cell_col = adr[CW-1:0];

    always_comb begin
        if (adr[`CELL_SPACE_BIT]) begin
            rd_word = DW'(cell_rd);    // Board returns empty for row or col past the edge
        end else begin
            case (adr)
                AW'(`ADDR_STATUS): rd_word = DW'({cursor_y, cursor_x, 3'b000, winner, turn, state});
                AW'(`ADDR_SCORES): rd_word = DW'({score_p2, score_p1});
                default:           rd_word = '0;
            endcase
        end
    end

    // ------------------------------
    // Handshake
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ack       <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (cmd_valid) begin
                if (cmd_done) begin
                    cmd_valid <= 1'b0;
                    ack       <= 1'b1;
                end
            end else if (new_req) begin
                if (we && is_cmd_addr && op_legal) begin
                    cmd_valid <= 1'b1;    // Ack waits for the core
                end else begin
                    ack <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_req && we) begin
            cmd_op <= cmd_t'(dat_w[$bits(cmd_t)-1:0]);
        end
        if (new_req && !we) begin
            dat_r <= rd_word;
        end
    end

endmodule

//--- source/line_scanner.sv
`timescale 1ns/1ns
`include "gomoku_settings.svh"

module line_scanner (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                scan_valid,
    input  gomoku_pkg::cell_t                   scan_player,
    input  gomoku_pkg::cell_t [`WINDOW_LEN-1:0] window,
    output logic                                hit,
    output logic                                hit_valid
);
    localparam int CTR = `WIN_LEN - 1;

    int run;

    // Run length through the centre up to the first foreign cell on each side
    always_comb begin
        logic run_on;
        run    = 0;
        run_on = 1'b0;
        if (window[CTR] == scan_player) begin
            run    = 1;
            run_on = 1'b1;
            for (int k = 1; k <= CTR; k++) begin
                if (run_on && window[CTR + k] == scan_player) begin
                    run = run + 1;
                end else begin
                    run_on = 1'b0;
                end
            end
            run_on = 1'b1;
            for (int k = 1; k <= CTR; k++) begin
                if (run_on && window[CTR - k] == scan_player) begin
                    run = run + 1;
                end else begin
                    run_on = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit       <= 1'b0;
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= scan_valid;
            hit       <= run >= `WIN_LEN;    // Only meaningful with hit_valid
        end
    end

endmodule
